// ==== hw/core_pkg.sv ====
package core_pkg;

	// Datapath and field widths
	localparam int WORD_W    = 32;
	localparam int REG_SEL_W = 3;
	localparam int OPC_W     = 4;
	localparam int CLASS_W   = 2;
	localparam int BC_W      = 3;
	localparam int MW_W      = 2;
	localparam int ST_W      = 2;

	// Instruction class, top two bits of the word
	localparam logic [CLASS_W-1:0] CLASS_ARITH  = 2'b00;
	localparam logic [CLASS_W-1:0] CLASS_BRANCH = 2'b01;
	localparam logic [CLASS_W-1:0] CLASS_MEM    = 2'b10;

	// Arithmetic opcodes
	localparam logic [OPC_W-1:0] OP_ADD    = 4'h0;
	localparam logic [OPC_W-1:0] OP_SUB    = 4'h1;
	localparam logic [OPC_W-1:0] OP_AND    = 4'h2;
	localparam logic [OPC_W-1:0] OP_OR     = 4'h3;
	localparam logic [OPC_W-1:0] OP_XOR    = 4'h4;
	localparam logic [OPC_W-1:0] OP_LSL    = 4'h5;
	localparam logic [OPC_W-1:0] OP_LSR    = 4'h6;
	localparam logic [OPC_W-1:0] OP_MOV    = 4'h7;
	localparam logic [OPC_W-1:0] OP_MOVHI  = 4'h8;
	localparam logic [OPC_W-1:0] OP_CMP    = 4'h9;
	// ALU-only code, never encoded in an instruction
	localparam logic [OPC_W-1:0] OP_BYPASS = 4'hf;

	// Branch opcodes
	localparam logic [OPC_W-1:0] OP_B    = 4'h0;
	localparam logic [OPC_W-1:0] OP_CALL = 4'h1;
	localparam logic [OPC_W-1:0] OP_RET  = 4'h2;
	localparam logic [OPC_W-1:0] OP_BNE  = 4'h3;
	localparam logic [OPC_W-1:0] OP_BEQ  = 4'h4;
	localparam logic [OPC_W-1:0] OP_BGT  = 4'h5;
	localparam logic [OPC_W-1:0] OP_BLT  = 4'h6;

	// Branch conditions as resolved in execute
	localparam logic [BC_W-1:0] BC_NONE   = 3'd0;
	localparam logic [BC_W-1:0] BC_NE     = 3'd1;
	localparam logic [BC_W-1:0] BC_EQ     = 3'd2;
	localparam logic [BC_W-1:0] BC_GT     = 3'd3;
	localparam logic [BC_W-1:0] BC_LT     = 3'd4;
	localparam logic [BC_W-1:0] BC_ALWAYS = 3'd7;

	// Memory width codes
	// Memory opcode bits 1:0 select them: 00 word, 01 half, 10 byte
	localparam logic [MW_W-1:0] MW_BYTE = 2'b00;
	localparam logic [MW_W-1:0] MW_HALF = 2'b01;
	localparam logic [MW_W-1:0] MW_WORD = 2'b10;

	// CALL writes, RET reads
	localparam logic [REG_SEL_W-1:0] LINK_REG = 3'd6;

	// Issue controller states
	localparam logic [ST_W-1:0] ST_IDLE  = 2'd0;
	localparam logic [ST_W-1:0] ST_EXEC  = 2'd1;
	localparam logic [ST_W-1:0] ST_ACKED = 2'd2;

	// Arithmetic and memory layout
	typedef struct packed {
		logic [CLASS_W-1:0]   iclass;
		logic [OPC_W-1:0]     opcode;
		logic [15:0]          imm16;
		logic                 rb_is_reg;
		logic [REG_SEL_W-1:0] rd;
		logic [REG_SEL_W-1:0] ra;
		logic [REG_SEL_W-1:0] rb;
	} imm_fmt_t;

	// Branch layout, shares class and opcode with the above
	typedef struct packed {
		logic [CLASS_W-1:0] iclass;
		logic [OPC_W-1:0]   opcode;
		logic               reg_target;
		logic               spare;
		logic [23:0]        imm24;
	} br_fmt_t;

	typedef union packed {
		imm_fmt_t imm_fmt;
		br_fmt_t  br_fmt;
	} instr_t;

endpackage

// ==== hw/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl (
	input  logic clk,
	input  logic arst_n,
	input  logic req,
	output logic ack,
	output logic dec_en,
	output logic ex_en
);

	import core_pkg::*;

	logic [ST_W-1:0] state;
	logic [ST_W-1:0] state_nxt;

	// Decode loads on the edge that first sees req in idle
	assign dec_en = (state == ST_IDLE) && req;
	// One execute cycle straight after decode
	assign ex_en = (state == ST_EXEC);
	// Ack is a decode of the state register, so glitch free
	assign ack = (state == ST_ACKED);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (req) begin
					state_nxt = ST_EXEC;
				end
			end
			ST_EXEC: begin
				// Results land on this edge together with ack
				state_nxt = ST_ACKED;
			end
			ST_ACKED: begin
				// Hold ack until the agent lets go of req
				if (!req) begin
					state_nxt = ST_IDLE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          dec_en,
	input  core_pkg::instr_t              instr,
	input  logic [core_pkg::WORD_W-1:0]   pc_plus_4,
	output logic [core_pkg::REG_SEL_W-1:0] ra_sel,
	output logic [core_pkg::REG_SEL_W-1:0] rb_sel,
	output logic [core_pkg::REG_SEL_W-1:0] rd_sel,
	output logic                          update_rd,
	output logic                          update_flags,
	output logic                          is_call,
	output logic [core_pkg::WORD_W-1:0]   imm32,
	output logic [core_pkg::OPC_W-1:0]    alu_opc,
	output logic [core_pkg::BC_W-1:0]     branch_condition,
	output logic                          alu_op1_ra,
	output logic                          alu_op2_rb,
	output logic                          mem_load,
	output logic                          mem_store,
	output logic [core_pkg::MW_W-1:0]     mem_width,
	output logic [core_pkg::WORD_W-1:0]   pc_plus_4_out
);

	import core_pkg::*;

	logic [CLASS_W-1:0] iclass;
	logic [OPC_W-1:0]   opcode;
	logic               is_arith;
	logic               is_branch;
	logic               is_mem;
	logic               reg_branch;
	logic [WORD_W-1:0]  imm16_sext;
	logic [WORD_W-1:0]  imm24_sext;
	logic [BC_W-1:0]    cond_nxt;
	logic [MW_W-1:0]    width_nxt;

	// Class and opcode sit at the same place in both layouts
	assign iclass    = instr.imm_fmt.iclass;
	assign opcode    = instr.imm_fmt.opcode;
	assign is_arith  = (iclass == CLASS_ARITH);
	assign is_branch = (iclass == CLASS_BRANCH);
	assign is_mem    = (iclass == CLASS_MEM);

	// RET always jumps through the link register
	assign reg_branch = is_branch && (instr.br_fmt.reg_target || opcode == OP_RET);

	assign imm16_sext = {{16{instr.imm_fmt.imm16[15]}}, instr.imm_fmt.imm16};
	// Word offset, so two zero bits at the bottom
	assign imm24_sext = {{6{instr.br_fmt.imm24[23]}}, instr.br_fmt.imm24, 2'b00};

	// Register selects stay combinational for the read in execute
	assign ra_sel = (is_branch && opcode == OP_RET) ? LINK_REG : instr.imm_fmt.ra;
	assign rb_sel = instr.imm_fmt.rb;

	always_comb begin
		cond_nxt = BC_NONE;
		if (is_branch) begin
			case (opcode)
				OP_BNE:  cond_nxt = BC_NE;
				OP_BEQ:  cond_nxt = BC_EQ;
				OP_BGT:  cond_nxt = BC_GT;
				OP_BLT:  cond_nxt = BC_LT;
				// B, CALL and RET
				default: cond_nxt = BC_ALWAYS;
			endcase
		end
	end

	always_comb begin
		case (opcode[1:0])
			2'b00:   width_nxt = MW_WORD;
			2'b01:   width_nxt = MW_HALF;
			default: width_nxt = MW_BYTE;
		endcase
	end

	// Control fields that must be quiet out of reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			update_rd        <= 1'b0;
			update_flags     <= 1'b0;
			is_call          <= 1'b0;
			mem_load         <= 1'b0;
			mem_store        <= 1'b0;
			branch_condition <= BC_NONE;
		end else if (dec_en) begin
			// CMP only sets the flags
			update_rd        <= is_arith && (opcode != OP_CMP);
			update_flags     <= is_arith && (opcode == OP_CMP);
			is_call          <= is_branch && (opcode == OP_CALL);
			// Opcode bit 2 splits store from load
			mem_load         <= is_mem && !opcode[2];
			mem_store        <= is_mem && opcode[2];
			branch_condition <= cond_nxt;
		end
	end

	// Operand and datapath fields
	always_ff @(posedge clk) begin
		if (dec_en) begin
			if (is_branch) begin
				imm32 <= imm24_sext;
			end else if (is_arith && opcode == OP_MOVHI) begin
				imm32 <= {instr.imm_fmt.imm16, 16'h0000};
			end else begin
				imm32 <= imm16_sext;
			end
			// Add forms both the memory address and relative targets
			if (is_arith) begin
				alu_opc <= opcode;
			end else if (reg_branch) begin
				alu_opc <= OP_BYPASS;
			end else begin
				alu_opc <= OP_ADD;
			end
			alu_op1_ra    <= is_arith || is_mem || reg_branch;
			alu_op2_rb    <= is_arith && instr.imm_fmt.rb_is_reg;
			rd_sel        <= instr.imm_fmt.rd;
			mem_width     <= width_nxt;
			pc_plus_4_out <= pc_plus_4;
		end
	end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic [core_pkg::REG_SEL_W-1:0] ra_sel,
	input  logic [core_pkg::REG_SEL_W-1:0] rb_sel,
	output logic [core_pkg::WORD_W-1:0]    ra_data,
	output logic [core_pkg::WORD_W-1:0]    rb_data,
	input  logic                           wr_en,
	input  logic [core_pkg::REG_SEL_W-1:0] wr_sel,
	input  logic [core_pkg::WORD_W-1:0]    wr_data
);

	import core_pkg::*;

	localparam int NUM_REGS = 1 << REG_SEL_W;

	logic [WORD_W-1:0] regs [NUM_REGS];

	// Two asynchronous read ports
	assign ra_data = regs[ra_sel];
	assign rb_data = regs[rb_sel];

	// Single write port, no bypass to the read side
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

endmodule

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           ex_en,
	input  logic [core_pkg::REG_SEL_W-1:0] rd_sel,
	input  logic                           update_rd,
	input  logic                           update_flags,
	input  logic                           is_call,
	input  logic [core_pkg::WORD_W-1:0]    imm32,
	input  logic [core_pkg::OPC_W-1:0]     alu_opc,
	input  logic [core_pkg::BC_W-1:0]      branch_condition,
	input  logic                           alu_op1_ra,
	input  logic                           alu_op2_rb,
	input  logic                           mem_load,
	input  logic                           mem_store,
	input  logic [core_pkg::MW_W-1:0]      mem_width,
	input  logic [core_pkg::WORD_W-1:0]    pc_plus_4,
	input  logic [core_pkg::WORD_W-1:0]    ra_data,
	input  logic [core_pkg::WORD_W-1:0]    rb_data,
	output logic                           wb_en,
	output logic [core_pkg::REG_SEL_W-1:0] wb_sel,
	output logic [core_pkg::WORD_W-1:0]    wb_data,
	output logic [core_pkg::WORD_W-1:0]    result,
	output logic                           wr_en,
	output logic [core_pkg::REG_SEL_W-1:0] wr_sel,
	output logic                           flag_z,
	output logic                           flag_gt,
	output logic                           flag_lt,
	output logic                           branch_taken,
	output logic [core_pkg::WORD_W-1:0]    branch_target,
	output logic [core_pkg::WORD_W-1:0]    mem_addr,
	output logic [core_pkg::WORD_W-1:0]    mem_wdata,
	output logic [core_pkg::MW_W-1:0]      mem_width_out,
	output logic                           mem_load_out,
	output logic                           mem_store_out,
	output logic                           result_valid
);

	import core_pkg::*;

	logic [WORD_W-1:0] op1;
	logic [WORD_W-1:0] op2;
	logic [WORD_W-1:0] alu_out;
	logic              cond_met;

	assign op1 = alu_op1_ra ? ra_data : pc_plus_4;
	assign op2 = alu_op2_rb ? rb_data : imm32;

	always_comb begin
		case (alu_opc)
			OP_ADD:    alu_out = op1 + op2;
			OP_SUB:    alu_out = op1 - op2;
			OP_AND:    alu_out = op1 & op2;
			OP_OR:     alu_out = op1 | op2;
			OP_XOR:    alu_out = op1 ^ op2;
			OP_LSL:    alu_out = op1 << op2[4:0];
			OP_LSR:    alu_out = op1 >> op2[4:0];
			OP_MOV:    alu_out = op2;
			OP_MOVHI:  alu_out = op2;
			// Result is dropped, only the flags matter
			OP_CMP:    alu_out = op1 - op2;
			// Register branch target straight from Ra
			OP_BYPASS: alu_out = op1;
			default:   alu_out = op1 + op2;
		endcase
	end

	// Flags from the previous CMP, not this instruction
	always_comb begin
		case (branch_condition)
			BC_NE:     cond_met = !flag_z;
			BC_EQ:     cond_met = flag_z;
			BC_GT:     cond_met = flag_gt;
			BC_LT:     cond_met = flag_lt;
			BC_ALWAYS: cond_met = 1'b1;
			default:   cond_met = 1'b0;
		endcase
	end

	// Register file write, lands on the ex_en edge
	assign wb_en   = ex_en && (update_rd || is_call);
	assign wb_sel  = is_call ? LINK_REG : rd_sel;
	// CALL saves the return address
	assign wb_data = is_call ? pc_plus_4 : alu_out;

	// Signed compare flags
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flag_z  <= 1'b0;
			flag_gt <= 1'b0;
			flag_lt <= 1'b0;
		end else if (ex_en && update_flags) begin
			flag_z  <= (op1 == op2);
			flag_gt <= ($signed(op1) > $signed(op2));
			flag_lt <= ($signed(op1) < $signed(op2));
		end
	end

	// Status bits held through the ack phase
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_en         <= 1'b0;
			branch_taken  <= 1'b0;
			mem_load_out  <= 1'b0;
			mem_store_out <= 1'b0;
			result_valid  <= 1'b0;
		end else begin
			// Single-cycle marker as the results register
			result_valid <= ex_en;
			if (ex_en) begin
				wr_en         <= update_rd || is_call;
				branch_taken  <= cond_met;
				mem_load_out  <= mem_load;
				mem_store_out <= mem_store;
			end
		end
	end

	// Payload, only meaningful alongside the status bits above
	always_ff @(posedge clk) begin
		if (ex_en) begin
			result        <= wb_data;
			wr_sel        <= wb_sel;
			branch_target <= alu_out;
			// Ra plus imm16 for loads and stores
			mem_addr      <= alu_out;
			mem_wdata     <= rb_data;
			mem_width_out <= mem_width;
		end
	end

endmodule

// ==== hw/core_top.sv ====
`timescale 1ns/1ps

module core_top (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           req,
	output logic                           ack,
	input  core_pkg::instr_t               instr,
	input  logic [core_pkg::WORD_W-1:0]    pc_plus_4,
	output logic [core_pkg::WORD_W-1:0]    result,
	output logic                           wr_en,
	output logic [core_pkg::REG_SEL_W-1:0] wr_sel,
	output logic                           flag_z,
	output logic                           flag_gt,
	output logic                           flag_lt,
	output logic                           branch_taken,
	output logic [core_pkg::WORD_W-1:0]    branch_target,
	output logic [core_pkg::WORD_W-1:0]    mem_addr,
	output logic [core_pkg::WORD_W-1:0]    mem_wdata,
	output logic [core_pkg::MW_W-1:0]      mem_width_out,
	output logic                           mem_load_out,
	output logic                           mem_store_out,
	output logic                           result_valid
);

	import core_pkg::*;

	// Strobes from the handshake FSM
	logic dec_en;
	logic ex_en;

	// Decode to execute
	logic [REG_SEL_W-1:0] ra_sel;
	logic [REG_SEL_W-1:0] rb_sel;
	logic [REG_SEL_W-1:0] rd_sel;
	logic                 update_rd;
	logic                 update_flags;
	logic                 is_call;
	logic [WORD_W-1:0]    imm32;
	logic [OPC_W-1:0]     alu_opc;
	logic [BC_W-1:0]      branch_condition;
	logic                 alu_op1_ra;
	logic                 alu_op2_rb;
	logic                 mem_load;
	logic                 mem_store;
	logic [MW_W-1:0]      mem_width;
	logic [WORD_W-1:0]    pc_plus_4_q;

	// Register file ports
	logic [WORD_W-1:0]    ra_data;
	logic [WORD_W-1:0]    rb_data;
	logic                 wb_en;
	logic [REG_SEL_W-1:0] wb_sel;
	logic [WORD_W-1:0]    wb_data;

	issue_ctrl issue_ctrl_i (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (req),
		.ack    (ack),
		.dec_en (dec_en),
		.ex_en  (ex_en)
	);

	instr_decode instr_decode_i (
		.clk              (clk),
		.arst_n           (arst_n),
		.dec_en           (dec_en),
		.instr            (instr),
		.pc_plus_4        (pc_plus_4),
		.ra_sel           (ra_sel),
		.rb_sel           (rb_sel),
		.rd_sel           (rd_sel),
		.update_rd        (update_rd),
		.update_flags     (update_flags),
		.is_call          (is_call),
		.imm32            (imm32),
		.alu_opc          (alu_opc),
		.branch_condition (branch_condition),
		.alu_op1_ra       (alu_op1_ra),
		.alu_op2_rb       (alu_op2_rb),
		.mem_load         (mem_load),
		.mem_store        (mem_store),
		.mem_width        (mem_width),
		.pc_plus_4_out    (pc_plus_4_q)
	);

	reg_file reg_file_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.ra_sel  (ra_sel),
		.rb_sel  (rb_sel),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.wr_en   (wb_en),
		.wr_sel  (wb_sel),
		.wr_data (wb_data)
	);

	exec_unit exec_unit_i (
		.clk              (clk),
		.arst_n           (arst_n),
		.ex_en            (ex_en),
		.rd_sel           (rd_sel),
		.update_rd        (update_rd),
		.update_flags     (update_flags),
		.is_call          (is_call),
		.imm32            (imm32),
		.alu_opc          (alu_opc),
		.branch_condition (branch_condition),
		.alu_op1_ra       (alu_op1_ra),
		.alu_op2_rb       (alu_op2_rb),
		.mem_load         (mem_load),
		.mem_store        (mem_store),
		.mem_width        (mem_width),
		.pc_plus_4        (pc_plus_4_q),
		.ra_data          (ra_data),
		.rb_data          (rb_data),
		.wb_en            (wb_en),
		.wb_sel           (wb_sel),
		.wb_data          (wb_data),
		.result           (result),
		.wr_en            (wr_en),
		.wr_sel           (wr_sel),
		.flag_z           (flag_z),
		.flag_gt          (flag_gt),
		.flag_lt          (flag_lt),
		.branch_taken     (branch_taken),
		.branch_target    (branch_target),
		.mem_addr         (mem_addr),
		.mem_wdata        (mem_wdata),
		.mem_width_out    (mem_width_out),
		.mem_load_out     (mem_load_out),
		.mem_store_out    (mem_store_out),
		.result_valid     (result_valid)
	);

endmodule

// ==== verif/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

	import core_pkg::*;

	localparam int CLK_HALF       = 5;
	localparam int RESET_CYCLES   = 16;
	localparam int DRIVE_DELAY    = 1;
	// Idle gap drawn from 0 to 3 cycles
	localparam int GAP_RANGE      = 4;
	localparam int CYCLES_PER_VEC = 20;
	localparam int NUM_FIELDS     = 11;
	localparam int MEM_DEPTH      = 1024;
	localparam int ADDR_W         = 10;
	// Word 0 holds the vector count
	localparam int MAX_VEC        = (MEM_DEPTH - 1) / NUM_FIELDS;
	localparam int NUM_REGS       = 1 << REG_SEL_W;

	// Column order in the vector file
	localparam int F_INSTR  = 0;
	localparam int F_PC     = 1;
	localparam int F_RESULT = 2;
	localparam int F_WR_EN  = 3;
	localparam int F_TAKEN  = 4;
	localparam int F_TARGET = 5;
	localparam int F_LOAD   = 6;
	localparam int F_STORE  = 7;
	localparam int F_ADDR   = 8;
	localparam int F_WDATA  = 9;
	localparam int F_WIDTH  = 10;

	logic                 clk;
	logic                 arst_n;
	logic                 req;
	logic                 ack;
	instr_t               instr;
	logic [WORD_W-1:0]    pc_plus_4;
	logic [WORD_W-1:0]    result;
	logic                 wr_en;
	logic [REG_SEL_W-1:0] wr_sel;
	logic                 flag_z;
	logic                 flag_gt;
	logic                 flag_lt;
	logic                 branch_taken;
	logic [WORD_W-1:0]    branch_target;
	logic [WORD_W-1:0]    mem_addr;
	logic [WORD_W-1:0]    mem_wdata;
	logic [MW_W-1:0]      mem_width_out;
	logic                 mem_load_out;
	logic                 mem_store_out;
	logic                 result_valid;

	logic [WORD_W-1:0] vec_mem [MEM_DEPTH];
	int                num_vec;
	int                seed = 67198;
	int                cycle_cnt = 0;
	int                cycle_limit = 0;

	// Register contents and flags rebuilt from the expected results
	logic [WORD_W-1:0]    model_regs [NUM_REGS];
	logic                 exp_z;
	logic                 exp_gt;
	logic                 exp_lt;
	logic [REG_SEL_W-1:0] exp_sel;

	core_top dut_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.req           (req),
		.ack           (ack),
		.instr         (instr),
		.pc_plus_4     (pc_plus_4),
		.result        (result),
		.wr_en         (wr_en),
		.wr_sel        (wr_sel),
		.flag_z        (flag_z),
		.flag_gt       (flag_gt),
		.flag_lt       (flag_lt),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_width_out (mem_width_out),
		.mem_load_out  (mem_load_out),
		.mem_store_out (mem_store_out),
		.result_valid  (result_valid)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#CLK_HALF;
			clk = ~clk;
		end
	end

	// Flat word address of one column of one vector
	function automatic logic [ADDR_W-1:0] word_addr(input int idx, input int field);
		return ADDR_W'(1 + idx * NUM_FIELDS + field);
	endfunction

	function automatic logic [WORD_W-1:0] vec_field(input int idx, input int field);
		return vec_mem[word_addr(idx, field)];
	endfunction

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic abort_run(input string what);
		$display("error at %0t: %s", $time, what);
		stop_run();
	endtask

	task automatic check_word(input string name, input logic [WORD_W-1:0] expected,
			input logic [WORD_W-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_width(input string name, input logic [MW_W-1:0] expected,
			input logic [MW_W-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_sel(input string name, input logic [REG_SEL_W-1:0] expected,
			input logic [REG_SEL_W-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			stop_run();
		end
	endtask

	// Everything quiet straight out of reset
	task automatic check_reset_state();
		check_bit("ack", 1'b0, ack);
		check_bit("wr_en", 1'b0, wr_en);
		check_bit("branch_taken", 1'b0, branch_taken);
		check_bit("mem_load_out", 1'b0, mem_load_out);
		check_bit("mem_store_out", 1'b0, mem_store_out);
		check_bit("result_valid", 1'b0, result_valid);
		check_bit("flag_z", 1'b0, flag_z);
		check_bit("flag_gt", 1'b0, flag_gt);
		check_bit("flag_lt", 1'b0, flag_lt);
	endtask

	// Signed compare on the tracked registers, write target from the fields
	task automatic predict_state(input int idx);
		instr_t            word;
		logic [WORD_W-1:0] exp_wr_en;
		int                a_val;
		int                b_val;
		shortint           imm_val;
		word      = vec_field(idx, F_INSTR);
		exp_wr_en = vec_field(idx, F_WR_EN);
		imm_val   = word.imm_fmt.imm16;
		a_val     = model_regs[word.imm_fmt.ra];
		if (word.imm_fmt.rb_is_reg) begin
			b_val = model_regs[word.imm_fmt.rb];
		end else begin
			b_val = imm_val;
		end
		if (word.imm_fmt.iclass == CLASS_ARITH && word.imm_fmt.opcode == OP_CMP) begin
			exp_z  = (a_val == b_val);
			exp_gt = (a_val > b_val);
			exp_lt = (a_val < b_val);
		end
		// CALL saves its return address in the link register
		if (word.br_fmt.iclass == CLASS_BRANCH && word.br_fmt.opcode == OP_CALL) begin
			exp_sel = LINK_REG;
		end else begin
			exp_sel = word.imm_fmt.rd;
		end
		if (exp_wr_en[0]) begin
			model_regs[exp_sel] = vec_field(idx, F_RESULT);
		end
	endtask

	task automatic check_results(input int idx);
		instr_t            word;
		logic [WORD_W-1:0] exp_load;
		logic [WORD_W-1:0] exp_store;
		logic [WORD_W-1:0] exp_wr_en;
		logic [WORD_W-1:0] exp_width;
		word      = vec_field(idx, F_INSTR);
		exp_load  = vec_field(idx, F_LOAD);
		exp_store = vec_field(idx, F_STORE);
		exp_wr_en = vec_field(idx, F_WR_EN);
		exp_width = vec_field(idx, F_WIDTH);
		// Status bits hold a defined value for every instruction
		check_bit("wr_en", exp_wr_en[0], wr_en);
		check_bit("branch_taken", vec_field(idx, F_TAKEN) != 0, branch_taken);
		check_bit("mem_load_out", exp_load[0], mem_load_out);
		check_bit("mem_store_out", exp_store[0], mem_store_out);
		check_bit("flag_z", exp_z, flag_z);
		check_bit("flag_gt", exp_gt, flag_gt);
		check_bit("flag_lt", exp_lt, flag_lt);
		// Payload only where it means something
		if (exp_wr_en[0]) begin
			check_word("result", vec_field(idx, F_RESULT), result);
			check_sel("wr_sel", exp_sel, wr_sel);
		end
		if (word.br_fmt.iclass == CLASS_BRANCH) begin
			check_word("branch_target", vec_field(idx, F_TARGET), branch_target);
		end
		if (exp_load[0] || exp_store[0]) begin
			check_word("mem_addr", vec_field(idx, F_ADDR), mem_addr);
			check_width("mem_width_out", exp_width[MW_W-1:0], mem_width_out);
		end
		if (exp_store[0]) begin
			check_word("mem_wdata", vec_field(idx, F_WDATA), mem_wdata);
		end
	endtask

	// Sampled one drive delay after the edge once outputs have settled
	task automatic wait_for_ack(input logic level);
		@(posedge clk);
		#DRIVE_DELAY;
		while (ack !== level) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	task automatic run_vector(input int idx);
		int gap;
		gap = $unsigned($random(seed)) % GAP_RANGE;
		predict_state(idx);
		// Junk on the bus while req is low
		repeat (gap) begin
			@(posedge clk);
			#DRIVE_DELAY;
			instr = $random(seed);
		end
		@(posedge clk);
		#DRIVE_DELAY;
		if (ack !== 1'b0) begin
			abort_run("ack was high before req was raised");
		end
		instr     = vec_field(idx, F_INSTR);
		pc_plus_4 = vec_field(idx, F_PC);
		req       = 1'b1;
		wait_for_ack(1'b1);
		// Valid marker rises on the same edge as ack
		check_bit("result_valid", 1'b1, result_valid);
		check_results(idx);
		// Ack and results must hold while req stays high
		@(posedge clk);
		#DRIVE_DELAY;
		if (ack !== 1'b1) begin
			abort_run("ack fell while req was still high");
		end
		check_results(idx);
		req   = 1'b0;
		instr = $random(seed);
		wait_for_ack(1'b0);
	endtask

	// Watchdog against a stuck handshake
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			abort_run("timeout, the handshakes did not complete within the cycle limit");
		end
	end

	initial begin
		arst_n    = 1'b0;
		req       = 1'b0;
		instr     = '0;
		pc_plus_4 = '0;
		// Register file and flags start cleared
		for (int r = 0; r < NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		exp_z   = 1'b0;
		exp_gt  = 1'b0;
		exp_lt  = 1'b0;
		exp_sel = '0;
		$readmemh("verif/core_testdata.txt", vec_mem);
		num_vec = int'(vec_mem[0]);
		if (num_vec < 1 || num_vec > MAX_VEC) begin
			abort_run("vector file is missing or its vector count is out of range");
		end
		cycle_limit = RESET_CYCLES + num_vec * CYCLES_PER_VEC;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b1;
		check_reset_state();
		for (int i = 0; i < num_vec; i++) begin
			run_vector(i);
		end
		$display("%0d vectors checked", num_vec);
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== core_top.f ====
hw/core_pkg.sv
hw/issue_ctrl.sv
hw/instr_decode.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/core_top.sv
verif/core_tb.sv

// ==== Makefile ====
# Verilator build and run for the issue, decode and execute core

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= core_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed!

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run check clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

check:
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/core_testdata.txt ====
// instr pc_plus_4 result wr_en taken target load store addr wdata width
// result checked on wr_en, target on branch words, addr/width on load or store, wdata on store
00000022
// MOV, MOVHI then OR
1c48d040 00000104 00001234 1 0 00000000 0 0 00000000 00000000 0
1fffc080 00000108 fffffff0 1 0 00000000 0 0 00000000 00000000 0
237ab4c0 0000010c dead0000 1 0 00000000 0 0 00000000 00000000 0
0dfbbcd8 00000110 dead7eef 1 0 00000000 0 0 00000000 00000000 0
// Register ALU ops
0000030a 00000114 00001224 1 0 00000000 0 0 00000000 00000000 0
0400034a 00000118 00001244 1 0 00000000 0 0 00000000 00000000 0
080003da 0000011c dead7ee0 1 0 00000000 0 0 00000000 00000000 0
100003fb 00000120 0000000f 1 0 00000000 0 0 00000000 00000000 0
1c001000 00000124 00000004 1 0 00000000 0 0 00000000 00000000 0
14000308 00000128 00012340 1 0 00000000 0 0 00000000 00000000 0
18000358 0000012c 0dead7ee 1 0 00000000 0 0 00000000 00000000 0
// Shift by immediate uses the low five bits
14009120 00000130 00123400 1 0 00000000 0 0 00000000 00000000 0
// CMP equal, then BEQ and BNE
24000209 00000134 00000000 0 0 00000000 0 0 00000000 00000000 0
50000002 00000138 00000000 0 1 00000140 0 0 00000000 00000000 0
4cffffff 0000013c 00000000 0 0 00000138 0 0 00000000 00000000 0
// CMP less than
24000211 00000140 00000000 0 0 00000000 0 0 00000000 00000000 0
58000010 00000144 00000000 0 1 00000184 0 0 00000000 00000000 0
54000010 00000148 00000000 0 0 00000188 0 0 00000000 00000000 0
// CMP greater than
2400020a 0000014c 00000000 0 0 00000000 0 0 00000000 00000000 0
54fffff0 00000150 00000000 0 1 00000110 0 0 00000000 00000000 0
58000003 00000154 00000000 0 0 00000160 0 0 00000000 00000000 0
50000003 00000158 00000000 0 0 00000164 0 0 00000000 00000000 0
4c000005 0000015c 00000000 0 1 00000170 0 0 00000000 00000000 0
// CALL, B, RET, branch through r5
44000100 00000160 00000160 1 1 00000560 0 0 00000000 00000000 0
40000020 00000164 00000000 0 1 000001e4 0 0 00000000 00000000 0
48000000 00000168 00000000 0 1 00000160 0 0 00000000 00000000 0
42000028 0000016c 00000000 0 1 0dead7ee 0 0 00000000 00000000 0
// Loads and stores
80004008 00000170 00000000 0 0 00000000 1 0 00001244 00000000 2
8bfff020 00000174 00000000 0 0 00000000 1 0 001233fc 00000000 0
9400041f 00000178 00000000 0 0 00000000 0 1 dead7ef0 0000000f 1
90040003 0000017c 00000000 0 0 00000000 0 1 00000104 dead7eef 2
98008015 00000180 00000000 0 0 00000000 0 1 00000010 0dead7ee 0
// Immediate SUB, then r6 read back
0400d048 00000184 00001200 1 0 00000000 0 0 00000000 00000000 0
000002b1 00000188 00001360 1 0 00000000 0 0 00000000 00000000 0
